//--- adxl_i2c.f
src/i2c_pkg.sv
src/adxl_pkg.sv
src/i2c_byte_engine.sv
src/bus_arbiter.sv
src/cpu_reg_access.sv
src/sample_poller.sv
src/adxl_i2c_top.sv
bench/adxl_sensor_model.sv
bench/adxl_i2c_checker.sv
bench/adxl_i2c_properties.sv
bench/tb_adxl_i2c.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_adxl_i2c
FILELIST  ?= adxl_i2c.f
LOG       ?= sim.log
FAIL_MSG  := Test failures found

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_adxl_i2c.sv
`timescale 1ns/1ps

module tb_adxl_i2c import adxl_pkg::*;;

	localparam int CLK_DIV = 4;
	localparam int ROWS    = 9;
	localparam int LIMIT   = ROWS * 150 * 16;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_BURST, OP_BOTH} op_t;
	typedef struct packed {
		op_t        op;
		logic [7:0] addr;
		logic [7:0] data;
		logic       refuse;
		logic [7:0] exp_rd;
	} row_t;

	logic i_clk, i_rst_n, i_cpu_start, i_cpu_write, i_drdy;
	logic [7:0] i_reg_addr, i_wr_data, o_rd_data;
	logic o_cpu_busy, o_cpu_done, o_cpu_nack, o_sample_valid, o_scl_oe, o_sda_oe;
	temp_t o_temp, exp_temp;
	acc_t o_acc_x, o_acc_y, o_acc_z, exp_x, exp_y, exp_z;
	logic scl_line, sda_line, model_sda_oe, refuse;
	logic chk_rd, exp_nack, sample_ok, done_first, chk_idle;
	logic [7:0] exp_rd;
	logic [7:0] exp_regs [256];
	row_t rows [ROWS];
	int errors, done_cnt, valid_cnt, stop_cnt, cycles, total;

	// open-drain lines, high unless someone pulls
	assign scl_line = !o_scl_oe;
	assign sda_line = !(o_sda_oe || model_sda_oe);

	adxl_i2c_top #(.CLK_DIV(CLK_DIV)) u_adxl_i2c_top (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_cpu_start(i_cpu_start),
		.i_cpu_write(i_cpu_write), .i_reg_addr(i_reg_addr), .i_wr_data(i_wr_data),
		.o_cpu_busy(o_cpu_busy), .o_cpu_done(o_cpu_done), .o_rd_data(o_rd_data),
		.o_cpu_nack(o_cpu_nack), .i_drdy(i_drdy), .o_temp(o_temp), .o_acc_x(o_acc_x),
		.o_acc_y(o_acc_y), .o_acc_z(o_acc_z), .o_sample_valid(o_sample_valid),
		.o_scl_oe(o_scl_oe), .o_sda_oe(o_sda_oe), .i_scl(scl_line), .i_sda(sda_line)
	);

	adxl_sensor_model u_model (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_scl(scl_line), .i_sda(sda_line),
		.i_refuse(refuse), .o_sda_oe(model_sda_oe), .o_stop_cnt(stop_cnt)
	);

	adxl_i2c_checker u_checker (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_scl_oe(o_scl_oe), .i_sda_oe(o_sda_oe),
		.i_cpu_busy(o_cpu_busy), .i_cpu_done(o_cpu_done), .i_rd_data(o_rd_data),
		.i_cpu_nack(o_cpu_nack), .i_sample_valid(o_sample_valid), .i_temp(o_temp),
		.i_acc_x(o_acc_x), .i_acc_y(o_acc_y), .i_acc_z(o_acc_z), .i_chk_rd(chk_rd),
		.i_exp_rd(exp_rd), .i_exp_nack(exp_nack), .i_sample_ok(sample_ok),
		.i_done_first(done_first), .i_chk_idle(chk_idle), .i_exp_temp(exp_temp),
		.i_exp_x(exp_x), .i_exp_y(exp_y), .i_exp_z(exp_z),
		.o_errors(errors), .o_done_cnt(done_cnt), .o_valid_cnt(valid_cnt)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic fill_regs();
		logic [31:0] s;
		s = 32'd93;
		for (int a = 0; a < 256; a++) begin
			s = xorshift(s);
			exp_regs[a] = s[7:0];
		end
		exp_regs[8]  = exp_regs[8] | 8'h80;	// x negative
		exp_regs[11] = exp_regs[11] & 8'h7f;	// y positive
		for (int a = 0; a < 256; a++)
			u_model.regs[a] = exp_regs[a];
	endtask

	// temp from TEMP2 low nibble and TEMP1, axes from three bytes each
	task automatic expect_samples();
		exp_temp = {exp_regs[6][3:0], exp_regs[7]};
		exp_x = {exp_regs[8], exp_regs[9], exp_regs[10][7:4]};
		exp_y = {exp_regs[11], exp_regs[12], exp_regs[13][7:4]};
		exp_z = {exp_regs[14], exp_regs[15], exp_regs[16][7:4]};
	endtask

	task automatic strobe(input logic cpu, input logic wr, input row_t r, input logic drdy);
		@(posedge i_clk);
		i_cpu_start <= cpu;
		i_cpu_write <= wr;
		i_reg_addr  <= r.addr;
		i_wr_data   <= r.data;
		i_drdy      <= drdy;
		@(posedge i_clk);
		i_cpu_start <= 1'b0;
		i_drdy      <= 1'b0;
	endtask

	task automatic check_idle();
		repeat (2) @(posedge i_clk);
		chk_idle <= 1'b1;
		@(posedge i_clk);
		chk_idle <= 1'b0;
		@(posedge i_clk);	// idle compare done before new expectations
	endtask

	task automatic run_row(input row_t r);
		int d0, v0, s0;
		d0 = done_cnt;
		v0 = valid_cnt;
		s0 = stop_cnt;
		refuse     = r.refuse;
		exp_nack   = r.refuse;
		exp_rd     = r.exp_rd;
		chk_rd     = (r.op == OP_READ || r.op == OP_BOTH) && !r.refuse;
		sample_ok  = (r.op == OP_BURST || r.op == OP_BOTH) && !r.refuse;
		done_first = (r.op == OP_BOTH);
		if (sample_ok)
			expect_samples();
		case (r.op)
			OP_WRITE, OP_READ: strobe(1'b1, r.op == OP_WRITE, r, 1'b0);
			OP_BURST: strobe(1'b0, 1'b0, r, 1'b1);
			default: strobe(1'b1, 1'b0, r, 1'b1);
		endcase
		if (r.op != OP_BURST)
			while (done_cnt == d0) @(posedge i_clk);
		if (r.op == OP_BURST && r.refuse) begin
			while (stop_cnt == s0) @(posedge i_clk);
			repeat (6 * CLK_DIV) @(posedge i_clk);	// STOP has a fixed length
		end else if (sample_ok) begin
			while (valid_cnt == v0) @(posedge i_clk);
		end
		if (r.op == OP_WRITE)
			exp_regs[r.addr] = r.data;
	endtask

	initial begin
		cycles = 0;
		forever begin
			@(posedge i_clk);
			cycles++;
			if (cycles >= LIMIT) begin
				$display("timeout, a transaction did not complete within %0d cycles", LIMIT);
				$display("Test failures found");
				$finish;
			end
		end
	end

	initial begin
		i_rst_n = 1'b0;
		i_cpu_start = 1'b0;
		i_cpu_write = 1'b0;
		i_reg_addr = '0;
		i_wr_data = '0;
		i_drdy = 1'b0;
		refuse = 1'b0;
		{chk_rd, exp_nack, sample_ok, done_first, chk_idle} = '0;
		exp_rd = '0;
		{exp_temp, exp_x, exp_y, exp_z} = '0;
		fill_regs();
		rows[0] = '{OP_WRITE, 8'h2A, 8'hC3, 1'b0, 8'h00};
		rows[1] = '{OP_READ,  8'h2A, 8'h00, 1'b0, 8'hC3};
		rows[2] = '{OP_READ,  8'h1F, 8'h00, 1'b0, exp_regs[8'h1F]};
		rows[3] = '{OP_BURST, 8'h00, 8'h00, 1'b0, 8'h00};
		rows[4] = '{OP_BOTH,  8'h11, 8'h00, 1'b0, exp_regs[8'h11]};
		rows[5] = '{OP_READ,  8'h2A, 8'h00, 1'b1, 8'h00};	// address refused
		rows[6] = '{OP_BURST, 8'h00, 8'h00, 1'b1, 8'h00};
		rows[7] = '{OP_WRITE, 8'h0E, 8'h81, 1'b0, 8'h00};	// z goes negative
		rows[8] = '{OP_BURST, 8'h00, 8'h00, 1'b0, 8'h00};
		repeat (2) @(posedge i_clk);
		i_rst_n <= 1'b1;
		check_idle();
		for (int i = 0; i < ROWS; i++) begin
			run_row(rows[i]);
			check_idle();
		end
		total = errors + u_adxl_i2c_top.u_props.fail_cnt;
		$display("errors: %0d checker, %0d assertion, %0d cpu done, %0d samples",
			errors, u_adxl_i2c_top.u_props.fail_cnt, done_cnt, valid_cnt);
		if (total == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- bench/adxl_i2c_properties.sv
`timescale 1ns/1ps

module adxl_i2c_properties import i2c_pkg::*; (
	input logic          i_clk,
	input logic          i_rst_n,
	input logic          i_cpu_gnt,
	input logic          i_poll_gnt,
	input logic          i_scl,
	input logic          i_sda,
	input engine_state_t i_state,
	input logic          i_cpu_done,
	input logic          i_cpu_busy
);

	int fail_cnt = 0;

	// at most one owner, and the engine only runs for an owner
	a_gnt_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0({i_cpu_gnt, i_poll_gnt}) && (i_state == IDLE || i_cpu_gnt || i_poll_gnt))
	else begin
		fail_cnt++;
		$error("both sequencers granted or engine running without a grant");
	end

	// data moves with scl low, START and STOP are the only exceptions
	a_sda_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_scl && $past(i_scl) && (i_sda != $past(i_sda))) |-> (i_state == START || i_state == STOP))
	else begin
		fail_cnt++;
		$error("sda changed while scl high outside START or STOP");
	end

	// done only once the STOP is over and the lines are free
	a_done_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_cpu_done |-> (!i_cpu_busy && i_state == IDLE && i_scl && i_sda))
	else begin
		fail_cnt++;
		$error("cpu done while the sequencer or the bus is still busy");
	end

endmodule

bind adxl_i2c_top adxl_i2c_properties u_props (
	.i_clk(i_clk), .i_rst_n(i_rst_n), .i_cpu_gnt(cpu_gnt), .i_poll_gnt(poll_gnt),
	.i_scl(i_scl), .i_sda(i_sda), .i_state(u_eng.state), .i_cpu_done(o_cpu_done),
	.i_cpu_busy(o_cpu_busy)
);

//--- bench/adxl_i2c_checker.sv
`timescale 1ns/1ps

module adxl_i2c_checker import adxl_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_scl_oe,
	input  logic       i_sda_oe,
	input  logic       i_cpu_busy,
	input  logic       i_cpu_done,
	input  logic [7:0] i_rd_data,
	input  logic       i_cpu_nack,
	input  logic       i_sample_valid,
	input  temp_t      i_temp,
	input  acc_t       i_acc_x,
	input  acc_t       i_acc_y,
	input  acc_t       i_acc_z,
	input  logic       i_chk_rd,
	input  logic [7:0] i_exp_rd,
	input  logic       i_exp_nack,
	input  logic       i_sample_ok,
	input  logic       i_done_first,
	input  logic       i_chk_idle,
	input  temp_t      i_exp_temp,
	input  acc_t       i_exp_x,
	input  acc_t       i_exp_y,
	input  acc_t       i_exp_z,
	output int         o_errors,
	output int         o_done_cnt,
	output int         o_valid_cnt
);

	logic done_seen;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			o_errors++;
			$display("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic compare_samples();
		compare("o_temp", 32'(i_temp), 32'(i_exp_temp));
		compare("o_acc_x", 32'(i_acc_x), 32'(i_exp_x));
		compare("o_acc_y", 32'(i_acc_y), 32'(i_exp_y));
		compare("o_acc_z", 32'(i_acc_z), 32'(i_exp_z));
	endtask

	initial begin
		o_errors    = 0;
		o_done_cnt  = 0;
		o_valid_cnt = 0;
		done_seen   = 1'b0;
	end

	always @(posedge i_clk) begin
		if (i_rst_n) begin
			if (i_cpu_done) begin
				o_done_cnt <= o_done_cnt + 1;
				done_seen = 1'b1;
				compare("o_cpu_nack", 32'(i_cpu_nack), 32'(i_exp_nack));
				if (i_chk_rd)
					compare("o_rd_data", 32'(i_rd_data), 32'(i_exp_rd));
			end
			if (i_sample_valid) begin
				o_valid_cnt <= o_valid_cnt + 1;
				if (!i_sample_ok) begin
					o_errors++;
					$display("sample valid seen at %0t where no burst should finish", $time);
				end else
					compare_samples();
				if (i_done_first && !done_seen) begin
					o_errors++;
					$display("burst finished at %0t before the cpu transaction", $time);
				end
			end
			if (i_chk_idle) begin	// quiet bus and held samples
				compare("o_scl_oe", 32'(i_scl_oe), 32'd0);
				compare("o_sda_oe", 32'(i_sda_oe), 32'd0);
				compare("o_cpu_busy", 32'(i_cpu_busy), 32'd0);
				compare("o_cpu_done", 32'(i_cpu_done), 32'd0);
				compare("o_sample_valid", 32'(i_sample_valid), 32'd0);
				compare_samples();
				done_seen = 1'b0;
			end
		end
	end

endmodule

//--- bench/adxl_sensor_model.sv
`timescale 1ns/1ps

module adxl_sensor_model import adxl_pkg::*; (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_scl,
	input  logic i_sda,
	input  logic i_refuse,
	output logic o_sda_oe,
	output int   o_stop_cnt
);

	typedef enum logic [2:0] {M_IDLE, M_ADDR, M_REG, M_WDATA, M_READ} mode_t;

	logic [7:0] regs [256];
	mode_t      mode;
	logic       scl_q, sda_q, in_ack, mst_ack;
	logic [3:0] cnt;
	logic [7:0] shreg, tx, ptr;

	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mode       <= M_IDLE;
			scl_q      <= 1'b1;
			sda_q      <= 1'b1;
			in_ack     <= 1'b0;
			mst_ack    <= 1'b0;
			cnt        <= '0;
			ptr        <= '0;
			o_sda_oe   <= 1'b0;
			o_stop_cnt <= 0;
		end else begin
			scl_q <= i_scl;
			sda_q <= i_sda;
			if (i_scl && scl_q && sda_q && !i_sda) begin	// start
				mode     <= M_ADDR;
				cnt      <= '0;
				in_ack   <= 1'b0;
				o_sda_oe <= 1'b0;
			end else if (i_scl && scl_q && !sda_q && i_sda) begin	// stop
				mode       <= M_IDLE;
				o_sda_oe   <= 1'b0;
				o_stop_cnt <= o_stop_cnt + 1;
			end else if (mode != M_IDLE && i_scl && !scl_q) begin
				if (in_ack)
					mst_ack <= !i_sda;
				else if (cnt < 4'd8) begin
					shreg <= {shreg[6:0], i_sda};
					cnt   <= cnt + 1'b1;
				end
			end else if (mode != M_IDLE && !i_scl && scl_q) begin
				if (in_ack) begin	// ninth clock over
					in_ack   <= 1'b0;
					cnt      <= '0;
					o_sda_oe <= 1'b0;
					if ((mode == M_ADDR && shreg[0]) || (mode == M_READ && mst_ack)) begin
						mode     <= M_READ;
						tx       <= regs[ptr];
						ptr      <= ptr + 1'b1;
						o_sda_oe <= !regs[ptr][7];
					end else if (mode == M_ADDR)
						mode <= M_REG;
					else if (mode == M_REG)
						mode <= M_WDATA;
					else if (mode == M_READ)
						mode <= M_IDLE;	// master nack
				end else if (cnt == 4'd8) begin
					in_ack <= 1'b1;
					case (mode)
						M_ADDR: begin
							if (shreg[7:1] == DEV_ADDR && !i_refuse)
								o_sda_oe <= 1'b1;
							else
								mode <= M_IDLE;
						end
						M_REG: begin
							ptr      <= shreg;
							o_sda_oe <= 1'b1;
						end
						M_WDATA: begin
							regs[ptr] <= shreg;
							ptr       <= ptr + 1'b1;
							o_sda_oe  <= 1'b1;
						end
						default: o_sda_oe <= 1'b0;	// master answers
					endcase
				end else if (mode == M_READ && cnt != 4'd0)
					o_sda_oe <= !tx[3'd7 - cnt[2:0]];
			end
		end
	end

endmodule

//--- src/adxl_i2c_top.sv
`timescale 1ns/1ps

module adxl_i2c_top import i2c_pkg::*, adxl_pkg::*; #(
	parameter int CLK_DIV = 4	// i_clk cycles per quarter scl period
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_cpu_start,
	input  logic              i_cpu_write,
	input  logic [BYTE_W-1:0] i_reg_addr,
	input  logic [BYTE_W-1:0] i_wr_data,
	output logic              o_cpu_busy,
	output logic              o_cpu_done,
	output logic [BYTE_W-1:0] o_rd_data,
	output logic              o_cpu_nack,
	input  logic              i_drdy,
	output temp_t             o_temp,
	output acc_t              o_acc_x,
	output acc_t              o_acc_y,
	output acc_t              o_acc_z,
	output logic              o_sample_valid,
	output logic              o_scl_oe,
	output logic              o_sda_oe,
	input  logic              i_scl,
	input  logic              i_sda
);

	logic cpu_req, cpu_gnt, cpu_cmd_valid, cpu_cmd_nack, cpu_done, cpu_ack_ok;
	logic poll_req, poll_gnt, poll_cmd_valid, poll_cmd_nack, poll_done, poll_ack_ok;
	logic eng_cmd_valid, eng_cmd_nack, eng_busy, eng_done, eng_ack_ok;
	i2c_cmd_t cpu_cmd, poll_cmd, eng_cmd;
	logic [BYTE_W-1:0] cpu_wdata, cpu_rdata, poll_wdata, poll_rdata, eng_wdata, eng_rdata;

	cpu_reg_access u_cpu (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_cpu_start(i_cpu_start),
		.i_cpu_write(i_cpu_write), .i_reg_addr(i_reg_addr), .i_wr_data(i_wr_data),
		.i_gnt(cpu_gnt), .i_done(cpu_done), .i_rdata(cpu_rdata), .i_ack_ok(cpu_ack_ok),
		.o_req(cpu_req), .o_cmd_valid(cpu_cmd_valid), .o_cmd(cpu_cmd),
		.o_wdata(cpu_wdata), .o_cmd_nack(cpu_cmd_nack), .o_cpu_busy(o_cpu_busy),
		.o_cpu_done(o_cpu_done), .o_rd_data(o_rd_data), .o_cpu_nack(o_cpu_nack)
	);

	sample_poller u_poll (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_drdy(i_drdy), .i_gnt(poll_gnt),
		.i_done(poll_done), .i_rdata(poll_rdata), .i_ack_ok(poll_ack_ok),
		.o_req(poll_req), .o_cmd_valid(poll_cmd_valid), .o_cmd(poll_cmd),
		.o_wdata(poll_wdata), .o_cmd_nack(poll_cmd_nack), .o_temp(o_temp),
		.o_acc_x(o_acc_x), .o_acc_y(o_acc_y), .o_acc_z(o_acc_z),
		.o_sample_valid(o_sample_valid)
	);

	bus_arbiter u_arb (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_cpu_req(cpu_req), .i_poll_req(poll_req),
		.i_cpu_cmd_valid(cpu_cmd_valid), .i_cpu_cmd(cpu_cmd), .i_cpu_wdata(cpu_wdata),
		.i_cpu_cmd_nack(cpu_cmd_nack), .i_poll_cmd_valid(poll_cmd_valid),
		.i_poll_cmd(poll_cmd), .i_poll_wdata(poll_wdata), .i_poll_cmd_nack(poll_cmd_nack),
		.i_eng_busy(eng_busy), .i_eng_done(eng_done), .i_eng_rdata(eng_rdata),
		.i_eng_ack_ok(eng_ack_ok), .o_cpu_gnt(cpu_gnt), .o_poll_gnt(poll_gnt),
		.o_eng_cmd_valid(eng_cmd_valid), .o_eng_cmd(eng_cmd), .o_eng_wdata(eng_wdata),
		.o_eng_cmd_nack(eng_cmd_nack), .o_cpu_done(cpu_done), .o_cpu_rdata(cpu_rdata),
		.o_cpu_ack_ok(cpu_ack_ok), .o_poll_done(poll_done), .o_poll_rdata(poll_rdata),
		.o_poll_ack_ok(poll_ack_ok)
	);

	i2c_byte_engine #(.CLK_DIV(CLK_DIV)) u_eng (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_cmd_valid(eng_cmd_valid), .i_cmd(eng_cmd),
		.i_wdata(eng_wdata), .i_cmd_nack(eng_cmd_nack), .i_sda(i_sda), .i_scl(i_scl),
		.o_busy(eng_busy), .o_done(eng_done), .o_rdata(eng_rdata), .o_ack_ok(eng_ack_ok),
		.o_scl_oe(o_scl_oe), .o_sda_oe(o_sda_oe)
	);

endmodule

//--- src/sample_poller.sv
`timescale 1ns/1ps

module sample_poller import i2c_pkg::*, adxl_pkg::*; (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_drdy,
	input  logic              i_gnt,
	input  logic              i_done,
	input  logic [BYTE_W-1:0] i_rdata,
	input  logic              i_ack_ok,
	output logic              o_req,
	output logic              o_cmd_valid,
	output i2c_cmd_t          o_cmd,
	output logic [BYTE_W-1:0] o_wdata,
	output logic              o_cmd_nack,
	output temp_t             o_temp,
	output acc_t              o_acc_x,
	output acc_t              o_acc_y,
	output acc_t              o_acc_z,
	output logic              o_sample_valid
);

	poll_seq_t         state;
	logic [2:0]        step;
	logic [3:0]        byte_cnt;
	logic              drdy_q;
	logic              aborted;
	logic              last_byte;
	logic [BYTE_W-1:0] burst_buf [BURST_LEN];

	assign last_byte   = (byte_cnt == 4'(BURST_LEN - 1));
	assign o_req       = (state != POLL_IDLE);
	assign o_cmd_valid = (state == POLL_CMD);

	// S, addr+w, TEMP2, P, S, addr+r, burst bytes, P
	always_comb begin
		o_cmd      = CMD_WRITE;
		o_wdata    = '1;
		o_cmd_nack = 1'b0;
		case (step)
			3'd0, 3'd4: o_cmd = CMD_START;
			3'd1: o_wdata = {DEV_ADDR, 1'b0};
			3'd2: o_wdata = REG_TEMP2;
			3'd5: o_wdata = {DEV_ADDR, 1'b1};
			3'd6: begin
				o_cmd      = CMD_READ;
				o_cmd_nack = last_byte;
			end
			default: o_cmd = CMD_STOP;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state          <= POLL_IDLE;
			step           <= '0;
			byte_cnt       <= '0;
			drdy_q         <= 1'b0;
			aborted        <= 1'b0;
			o_temp         <= '0;
			o_acc_x        <= '0;
			o_acc_y        <= '0;
			o_acc_z        <= '0;
			o_sample_valid <= 1'b0;
		end else begin
			drdy_q         <= i_drdy;
			o_sample_valid <= 1'b0;
			case (state)
				POLL_IDLE: if (i_drdy && !drdy_q) begin	// edges while busy are dropped
					step     <= '0;
					byte_cnt <= '0;
					aborted  <= 1'b0;
					state    <= POLL_REQ;
				end
				POLL_REQ: if (i_gnt) state <= POLL_CMD;
				POLL_CMD: state <= POLL_WAIT;
				default: if (i_done) begin
					state <= POLL_CMD;
					if ((step == 3'd1 || step == 3'd5) && !i_ack_ok) begin
						aborted <= 1'b1;
						step    <= 3'd7;
					end else if (step == 3'd6) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (last_byte)
							step <= 3'd7;
					end else if (step == 3'd7) begin
						state <= POLL_IDLE;
						if (!aborted) begin
							o_temp  <= {burst_buf[0][3:0], burst_buf[1]};
							o_acc_x <= {burst_buf[2], burst_buf[3], burst_buf[4][7:4]};
							o_acc_y <= {burst_buf[5], burst_buf[6], burst_buf[7][7:4]};
							o_acc_z <= {burst_buf[8], burst_buf[9], burst_buf[10][7:4]};
							o_sample_valid <= 1'b1;
						end
					end else begin
						step <= step + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == POLL_WAIT && i_done && step == 3'd6)
			burst_buf[byte_cnt] <= i_rdata;
	end

endmodule

//--- src/cpu_reg_access.sv
`timescale 1ns/1ps

module cpu_reg_access import i2c_pkg::*, adxl_pkg::*; (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_cpu_start,
	input  logic              i_cpu_write,
	input  logic [BYTE_W-1:0] i_reg_addr,
	input  logic [BYTE_W-1:0] i_wr_data,
	input  logic              i_gnt,
	input  logic              i_done,
	input  logic [BYTE_W-1:0] i_rdata,
	input  logic              i_ack_ok,
	output logic              o_req,
	output logic              o_cmd_valid,
	output i2c_cmd_t          o_cmd,
	output logic [BYTE_W-1:0] o_wdata,
	output logic              o_cmd_nack,
	output logic              o_cpu_busy,
	output logic              o_cpu_done,
	output logic [BYTE_W-1:0] o_rd_data,
	output logic              o_cpu_nack
);

	cpu_seq_t          state;
	logic [2:0]        step;
	logic              wr_q;
	logic              nack_seen;
	logic [BYTE_W-1:0] reg_q;
	logic [BYTE_W-1:0] data_q;
	logic [2:0]        last_step;
	logic              addr_step;

	// write: S, addr+w, reg, data, P
	// read:  S, addr+w, reg, P, S, addr+r, byte, P
	assign last_step   = wr_q ? 3'd4 : 3'd7;
	assign addr_step   = (step == 3'd1) || (!wr_q && step == 3'd5);
	assign o_req       = (state != CPU_IDLE);
	assign o_cpu_busy  = (state != CPU_IDLE);
	assign o_cmd_valid = (state == CPU_CMD);

	always_comb begin
		o_cmd      = CMD_WRITE;
		o_wdata    = '1;
		o_cmd_nack = 1'b0;
		case (step)
			3'd0: o_cmd = CMD_START;
			3'd1: o_wdata = {DEV_ADDR, 1'b0};
			3'd2: o_wdata = reg_q;
			3'd3: begin
				if (wr_q)
					o_wdata = data_q;
				else
					o_cmd = CMD_STOP;	// pointer write ends here
			end
			3'd4: o_cmd = wr_q ? CMD_STOP : CMD_START;
			3'd5: o_wdata = {DEV_ADDR, 1'b1};
			3'd6: begin
				o_cmd      = CMD_READ;
				o_cmd_nack = 1'b1;	// single byte, so it is the last
			end
			default: o_cmd = CMD_STOP;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= CPU_IDLE;
			step       <= '0;
			wr_q       <= 1'b0;
			nack_seen  <= 1'b0;
			o_cpu_done <= 1'b0;
			o_cpu_nack <= 1'b0;
		end else begin
			o_cpu_done <= 1'b0;
			case (state)
				CPU_IDLE: if (i_cpu_start) begin
					wr_q      <= i_cpu_write;
					step      <= '0;
					nack_seen <= 1'b0;
					state     <= CPU_REQ;
				end
				CPU_REQ: if (i_gnt) state <= CPU_CMD;
				CPU_CMD: state <= CPU_WAIT;
				default: if (i_done) begin
					if (addr_step && !i_ack_ok) begin
						nack_seen <= 1'b1;	// abort to stop
						step      <= last_step;
						state     <= CPU_CMD;
					end else if (step == last_step) begin
						state      <= CPU_IDLE;
						o_cpu_done <= 1'b1;
						o_cpu_nack <= nack_seen;
					end else begin
						step  <= step + 1'b1;
						state <= CPU_CMD;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == CPU_IDLE && i_cpu_start) begin
			reg_q  <= i_reg_addr;
			data_q <= i_wr_data;
		end
		if (state == CPU_WAIT && i_done && step == 3'd6)
			o_rd_data <= i_rdata;
	end

endmodule

//--- src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import i2c_pkg::*; (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_cpu_req,
	input  logic              i_poll_req,
	input  logic              i_cpu_cmd_valid,
	input  i2c_cmd_t          i_cpu_cmd,
	input  logic [BYTE_W-1:0] i_cpu_wdata,
	input  logic              i_cpu_cmd_nack,
	input  logic              i_poll_cmd_valid,
	input  i2c_cmd_t          i_poll_cmd,
	input  logic [BYTE_W-1:0] i_poll_wdata,
	input  logic              i_poll_cmd_nack,
	input  logic              i_eng_busy,
	input  logic              i_eng_done,
	input  logic [BYTE_W-1:0] i_eng_rdata,
	input  logic              i_eng_ack_ok,
	output logic              o_cpu_gnt,
	output logic              o_poll_gnt,
	output logic              o_eng_cmd_valid,
	output i2c_cmd_t          o_eng_cmd,
	output logic [BYTE_W-1:0] o_eng_wdata,
	output logic              o_eng_cmd_nack,
	output logic              o_cpu_done,
	output logic [BYTE_W-1:0] o_cpu_rdata,
	output logic              o_cpu_ack_ok,
	output logic              o_poll_done,
	output logic [BYTE_W-1:0] o_poll_rdata,
	output logic              o_poll_ack_ok
);

	// grant held for a whole transaction, cpu wins a tie
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_cpu_gnt  <= 1'b0;
			o_poll_gnt <= 1'b0;
		end else if (o_cpu_gnt) begin
			o_cpu_gnt <= i_cpu_req;
		end else if (o_poll_gnt) begin
			o_poll_gnt <= i_poll_req;
		end else if (!i_eng_busy) begin
			o_cpu_gnt  <= i_cpu_req;
			o_poll_gnt <= i_poll_req && !i_cpu_req;
		end
	end

	assign o_eng_cmd_valid = !i_eng_busy &&
		((o_cpu_gnt && i_cpu_cmd_valid) || (o_poll_gnt && i_poll_cmd_valid));
	assign o_eng_cmd      = o_poll_gnt ? i_poll_cmd : i_cpu_cmd;
	assign o_eng_wdata    = o_poll_gnt ? i_poll_wdata : i_cpu_wdata;
	assign o_eng_cmd_nack = o_poll_gnt ? i_poll_cmd_nack : i_cpu_cmd_nack;

	// results only reach the owner
	assign o_cpu_done    = o_cpu_gnt && i_eng_done;
	assign o_cpu_rdata   = o_cpu_gnt ? i_eng_rdata : '0;
	assign o_cpu_ack_ok  = o_cpu_gnt && i_eng_ack_ok;
	assign o_poll_done   = o_poll_gnt && i_eng_done;
	assign o_poll_rdata  = o_poll_gnt ? i_eng_rdata : '0;
	assign o_poll_ack_ok = o_poll_gnt && i_eng_ack_ok;

endmodule

//--- src/i2c_byte_engine.sv
`timescale 1ns/1ps

module i2c_byte_engine import i2c_pkg::*; #(
	parameter int CLK_DIV = 4
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_cmd_valid,
	input  i2c_cmd_t          i_cmd,
	input  logic [BYTE_W-1:0] i_wdata,
	input  logic              i_cmd_nack,
	input  logic              i_sda,
	input  logic              i_scl,
	output logic              o_busy,
	output logic              o_done,
	output logic [BYTE_W-1:0] o_rdata,
	output logic              o_ack_ok,
	output logic              o_scl_oe,
	output logic              o_sda_oe
);

	localparam int DIV_W = ($clog2(CLK_DIV) > 0) ? $clog2(CLK_DIV) : 1;

	engine_state_t     state;
	logic [DIV_W-1:0]  div_cnt;
	logic [1:0]        qtr;		// quarter within the current bit
	logic [2:0]        bit_idx;
	logic [BYTE_W-1:0] shift;
	logic              rx_q;
	logic              rd_mode;
	logic              nack_mode;
	logic              scl_hold;	// line levels kept between commands
	logic              sda_hold;
	logic              tick;
	logic              last_qtr;
	logic              rx_bit;
	logic              bit_low;
	logic              ack_low;

	assign tick     = (div_cnt == DIV_W'(CLK_DIV - 1));
	assign last_qtr = tick && (qtr == 2'd3);
	assign rx_bit   = i_scl ? i_sda : 1'b1;	// scl held low reads as released
	assign bit_low  = !rd_mode && !shift[BYTE_W-1];
	assign ack_low  = rd_mode && !nack_mode;
	assign o_busy   = (state != IDLE);
	assign o_rdata  = shift;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= IDLE;
			div_cnt   <= '0;
			qtr       <= '0;
			bit_idx   <= '0;
			rd_mode   <= 1'b0;
			nack_mode <= 1'b0;
			scl_hold  <= 1'b0;
			sda_hold  <= 1'b0;
			o_done    <= 1'b0;
			o_ack_ok  <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (state == IDLE) begin
				div_cnt <= '0;
				qtr     <= '0;
				if (i_cmd_valid) begin
					rd_mode   <= (i_cmd == CMD_READ);
					nack_mode <= i_cmd_nack;
					bit_idx   <= 3'd7;	// msb first
					case (i_cmd)
						CMD_START: state <= START;
						CMD_STOP:  state <= STOP;
						default:   state <= BIT;
					endcase
				end
			end else begin
				div_cnt <= tick ? '0 : div_cnt + 1'b1;
				if (tick)
					qtr <= qtr + 1'b1;
				// slave ack sampled mid scl high
				if (state == ACK && tick && qtr == 2'd1 && !rd_mode)
					o_ack_ok <= !rx_bit;
				if (last_qtr) begin
					case (state)
						START: begin
							state    <= IDLE;
							o_done   <= 1'b1;
							scl_hold <= 1'b1;
							sda_hold <= 1'b1;
						end
						BIT: begin
							if (bit_idx == 3'd0)
								state <= ACK;
							else
								bit_idx <= bit_idx - 1'b1;
						end
						ACK: begin
							state    <= IDLE;
							o_done   <= 1'b1;
							scl_hold <= 1'b1;	// park with scl low
							sda_hold <= ack_low;
						end
						default: begin	// STOP leaves both lines released
							state    <= IDLE;
							o_done   <= 1'b1;
							scl_hold <= 1'b0;
							sda_hold <= 1'b0;
						end
					endcase
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == IDLE && i_cmd_valid)
			shift <= i_wdata;
		else if (state == BIT && last_qtr)
			shift <= {shift[BYTE_W-2:0], rx_q};
		if (state == BIT && tick && qtr == 2'd1)
			rx_q <= rx_bit;
	end

	// scl low in quarters 0 and 3, sda only moves at quarter 0 of a bit
	always_comb begin
		o_scl_oe = scl_hold;
		o_sda_oe = sda_hold;
		case (state)
			START: begin
				o_scl_oe = (qtr == 2'd3);
				o_sda_oe = (qtr != 2'd0);	// sda falls while scl high
			end
			BIT: begin
				o_scl_oe = (qtr == 2'd0) || (qtr == 2'd3);
				o_sda_oe = bit_low;
			end
			ACK: begin
				o_scl_oe = (qtr == 2'd0) || (qtr == 2'd3);
				o_sda_oe = ack_low;
			end
			STOP: begin
				o_scl_oe = (qtr == 2'd0);
				o_sda_oe = (qtr < 2'd2);	// sda rises while scl high
			end
			default: ;
		endcase
	end

endmodule

//--- src/adxl_pkg.sv
package adxl_pkg;

	localparam logic [6:0] DEV_ADDR  = 7'h1D;
	localparam logic [7:0] REG_TEMP2 = 8'h06;	// TEMP2, TEMP1, XDATA3 .. ZDATA1 follow

	localparam int BURST_LEN = 11;
	localparam int TEMP_W    = 12;
	localparam int ACC_W     = 20;

	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [TEMP_W-1:0]       temp_t;

	// cpu register access sequencer
	typedef enum logic [2:0] {
		CPU_IDLE,
		CPU_REQ,
		CPU_CMD,
		CPU_WAIT
	} cpu_seq_t;

	// data-ready burst sequencer
	typedef enum logic [2:0] {
		POLL_IDLE,
		POLL_REQ,
		POLL_CMD,
		POLL_WAIT
	} poll_seq_t;

endpackage

//--- src/i2c_pkg.sv
package i2c_pkg;

	localparam int BYTE_W = 8;

	// commands accepted by the byte engine
	typedef enum logic [1:0] {
		CMD_START,
		CMD_WRITE,
		CMD_READ,
		CMD_STOP
	} i2c_cmd_t;

	// engine phases, BIT covers the 8 data bits and ACK the ninth
	typedef enum logic [2:0] {
		IDLE,
		START,
		BIT,
		ACK,
		STOP
	} engine_state_t;

endpackage
